// File: rtl/a53_pkg.sv
// Shared widths, register select codes, reset values and memory prefixes
// Written data word with its mode and bank views
`default_nettype none

package a53_pkg;

	// Bus widths
	localparam int CPU_ADDR_W = 16;
	localparam int PPU_ADDR_W = 14;
	localparam int MEM_ADDR_W = 22; // Cartridge memory space
	localparam int DATA_W     = 8;

	// Register widths
	localparam int INNER_W    = 4;
	localparam int OUTER_W    = 6;
	localparam int MODE_W     = 6;
	localparam int CHR_BANK_W = 2;
	localparam int PRG_BANK_W = 7; // 16K bank number, A14..A20
	localparam int SEL_W      = 2;

	// Select register codes
	localparam logic [SEL_W-1:0] SEL_CHR   = 2'd0;
	localparam logic [SEL_W-1:0] SEL_INNER = 2'd1;
	localparam logic [SEL_W-1:0] SEL_MODE  = 2'd2;
	localparam logic [SEL_W-1:0] SEL_OUTER = 2'd3;

	// Values after reset
	localparam logic [SEL_W-1:0]   SEL_RESET   = SEL_INNER;
	localparam logic [OUTER_W-1:0] OUTER_RESET = '1; // Last bank

	// Memory region prefixes
	localparam logic [8:0] PRG_RAM_PREFIX = 9'b111100000; // 8K work RAM
	localparam logic [6:0] CHR_PREFIX     = 7'b1000000;   // CHR RAM base

	// Mirroring codes in mode bits 1:0
	localparam logic [1:0] MIR_ONE_LO = 2'd0;
	localparam logic [1:0] MIR_ONE_HI = 2'd1;
	localparam logic [1:0] MIR_VERT   = 2'd2;
	localparam logic [1:0] MIR_HORZ   = 2'd3;

	// Data byte seen as a mode register write
	typedef struct packed {
		logic [1:0] pad;
		logic [1:0] size;     // Outer bank size 32K..256K
		logic [1:0] prg_mode; // NROM or UNROM layout
		logic [1:0] mirror;
	} a53_mode_wd_t;

	// Data byte seen as a CHR or inner bank write
	typedef struct packed {
		logic [2:0]         pad;
		logic               page; // One-screen page
		logic [INNER_W-1:0] bank;
	} a53_bank_wd_t;

	typedef union packed {
		a53_mode_wd_t mode_w;
		a53_bank_wd_t bank_w;
	} a53_wdata_u;

endpackage

`default_nettype wire

// File: rtl/a53_cpu_port.sv
// CPU write decoder and select register
`timescale 1ns/100ps
`default_nettype none

module a53_cpu_port (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           ce,
	input  logic [a53_pkg::CPU_ADDR_W-1:0] prg_ain,
	input  logic                           prg_write,
	input  logic [a53_pkg::DATA_W-1:0]     prg_din,
	output logic                           bank_we, // Register window write
	output logic [a53_pkg::SEL_W-1:0]      sel
);

	logic cpu_we;   // Qualified CPU write
	logic sel_hit;  // $5000-$5FFF
	logic sel_we;

	assign cpu_we  = ce && prg_write;
	assign sel_hit = (prg_ain[15:12] == 4'h5);
	assign sel_we  = cpu_we && sel_hit;

	// Any write to $8000-$FFFF hits the selected register
	assign bank_we = cpu_we && prg_ain[15];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel <= a53_pkg::SEL_RESET;
		end else if (sel_we) begin
			sel <= {prg_din[7], prg_din[0]}; // D7 picks mode/outer group
		end
	end

	// Select register moves only after a CPU cycle
	a_sel_needs_ce: assert property (
		@(posedge clk) disable iff (!arst_n)
		!ce |=> $stable(sel)
	) else $error("sel changed without ce");

endmodule

`default_nettype wire

// File: rtl/a53_bank_regs.sv
// CHR, inner, mode and outer bank registers
// Decodes the written byte as a mode word or a bank word
`timescale 1ns/100ps
`default_nettype none

module a53_bank_regs (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            bank_we,
	input  logic [a53_pkg::SEL_W-1:0]       sel,
	input  logic [a53_pkg::DATA_W-1:0]      prg_din,
	output logic [a53_pkg::INNER_W-1:0]     inner,
	output logic [a53_pkg::OUTER_W-1:0]     outer,
	output logic [a53_pkg::MODE_W-1:0]      mode,
	output logic [a53_pkg::CHR_BANK_W-1:0]  chr_bank
);

	a53_pkg::a53_wdata_u wd; // Byte under both views

	logic chr_we;
	logic inner_we;
	logic mode_we;
	logic outer_we;
	logic page_we;  // One-screen page follows bank writes

	assign wd = prg_din;

	assign chr_we   = bank_we && (sel == a53_pkg::SEL_CHR);
	assign inner_we = bank_we && (sel == a53_pkg::SEL_INNER);
	assign mode_we  = bank_we && (sel == a53_pkg::SEL_MODE);
	assign outer_we = bank_we && (sel == a53_pkg::SEL_OUTER);

	// Only while mirroring is one-screen
	assign page_we = (chr_we || inner_we) && !mode[1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			chr_bank <= '0;
		end else if (chr_we) begin
			chr_bank <= wd.bank_w.bank[a53_pkg::CHR_BANK_W-1:0]; // 8K CHR RAM page
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			inner <= '0;
		end else if (inner_we) begin
			inner <= wd.bank_w.bank;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			outer <= a53_pkg::OUTER_RESET; // Boot from last bank
		end else if (outer_we) begin
			outer <= prg_din[a53_pkg::OUTER_W-1:0];
		end
	end

	// Full mode write, or just the page bit from a bank write
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mode <= '0; // One-screen lower, 32K NROM
		end else if (mode_we) begin
			mode <= {wd.mode_w.size, wd.mode_w.prg_mode, wd.mode_w.mirror};
		end else if (page_we) begin
			mode[0] <= wd.bank_w.page;
		end
	end

	// Mode register holds the written byte one cycle later
	a_mode_write: assert property (
		@(posedge clk) disable iff (!arst_n)
		mode_we |=> (mode == $past(prg_din[a53_pkg::MODE_W-1:0]))
	) else $error("mode register does not match written data");

endmodule

`default_nettype wire

// File: rtl/a53_prg_map.sv
// CPU side address mapper
// PRG bank composition, PRG RAM window and access permission
`timescale 1ns/100ps
`default_nettype none

module a53_prg_map (
	input  logic [a53_pkg::CPU_ADDR_W-1:0] prg_ain,
	input  logic                           prg_write,
	input  logic                           prg_ram_present,
	input  logic [a53_pkg::INNER_W-1:0]    inner,
	input  logic [a53_pkg::OUTER_W-1:0]    outer,
	input  logic [a53_pkg::MODE_W-1:0]     mode,
	output logic [a53_pkg::MEM_ADDR_W-1:0] prg_aout,
	output logic                           prg_allow
);

	localparam int OW = a53_pkg::OUTER_W;
	localparam int BW = a53_pkg::PRG_BANK_W;

	logic [1:0]    size;       // 0..3 for 32K..256K outer banks
	logic          unrom;      // Layout with a fixed half
	logic          a14;
	logic          switch_half;
	logic [OW-1:0] nrom_mask;  // Low size bits come from inner
	logic [BW-1:0] unrom_mask; // Low size+1 bits come from inner
	logic [OW-1:0] inner_ow;
	logic [BW-1:0] inner_bw;
	logic [BW-1:0] nrom_bank;
	logic [BW-1:0] unrom_bank;
	logic [BW-1:0] fixed_bank;
	logic [BW-1:0] prg_bank;
	logic          prg_is_ram;
	logic          rom_read;

	assign size  = mode[5:4];
	assign unrom = mode[3];
	assign a14   = prg_ain[14];

	// $C000 switches for mode 2, $8000 for mode 3
	assign switch_half = unrom && (a14 ^ mode[2]);

	assign nrom_mask  = ~({OW{1'b1}} << size);
	assign unrom_mask = ~({BW{1'b1}} << (size + 3'd1));
	assign inner_ow   = OW'(inner);
	assign inner_bw   = BW'(inner);

	// 32K bank with the inner bits merged in, then A14
	assign nrom_bank = {(outer & ~nrom_mask) | (inner_ow & nrom_mask), a14};

	// 16K bank inside the outer bank
	assign unrom_bank = ({outer, 1'b0} & ~unrom_mask) | (inner_bw & unrom_mask);

	assign fixed_bank = {outer, a14}; // Other half stays at the outer bank

	always_comb begin
		if (!unrom) begin
			prg_bank = nrom_bank;
		end else if (switch_half) begin
			prg_bank = unrom_bank;
		end else begin
			prg_bank = fixed_bank;
		end
	end

	assign prg_is_ram = (prg_ain[15:13] == 3'b011) && prg_ram_present; // $6000-$7FFF
	assign rom_read   = prg_ain[15] && !prg_write;

	always_comb begin
		if (prg_is_ram) begin
			prg_aout = {a53_pkg::PRG_RAM_PREFIX, prg_ain[12:0]};
		end else begin
			prg_aout = {1'b0, prg_bank, prg_ain[13:0]};
		end
	end

	assign prg_allow = prg_is_ram || rom_read;

	// ROM is never written from the CPU
	always_comb begin
		a_no_rom_write: assert final (!(prg_allow && prg_write && prg_ain[15]))
			else $error("prg_allow high for a ROM write");
	end

endmodule

`default_nettype wire

// File: rtl/a53_ppu_map.sv
// PPU side address mapper
// CHR RAM banking and nametable mirroring
`timescale 1ns/100ps
`default_nettype none

module a53_ppu_map (
	input  logic [a53_pkg::PPU_ADDR_W-1:0] chr_ain,
	input  logic                           chr_is_ram,
	input  logic [a53_pkg::MODE_W-1:0]     mode,
	input  logic [a53_pkg::CHR_BANK_W-1:0] chr_bank,
	output logic [a53_pkg::MEM_ADDR_W-1:0] chr_aout,
	output logic                           chr_allow,
	output logic                           vram_a10,
	output logic                           vram_ce
);

	logic [1:0] mirror; // Mode bits 1:0

	assign mirror = mode[1:0];

	// 8K CHR RAM page picked by chr_bank
	assign chr_aout = {a53_pkg::CHR_PREFIX, chr_bank, chr_ain[12:0]};

	assign chr_allow = chr_is_ram; // Writable only when RAM fitted
	assign vram_ce   = chr_ain[13]; // Nametables in console VRAM

	always_comb begin
		case (mirror)
			a53_pkg::MIR_ONE_LO,
			a53_pkg::MIR_ONE_HI: vram_a10 = mode[0];     // Page bit is the code's low bit
			a53_pkg::MIR_VERT:   vram_a10 = chr_ain[10];
			a53_pkg::MIR_HORZ:   vram_a10 = chr_ain[11];
			default:             vram_a10 = chr_ain[10];
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/a53_top.sv
// Action 53 mapper top level
// CPU write port, bank registers and the PRG and PPU address mappers
`timescale 1ns/100ps
`default_nettype none

module a53_top (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            ce,              // CPU cycle strobe
	input  logic [a53_pkg::CPU_ADDR_W-1:0]  prg_ain,
	input  logic                            prg_write,
	input  logic [a53_pkg::DATA_W-1:0]      prg_din,
	input  logic                            prg_ram_present, // Cartridge has work RAM
	input  logic                            chr_is_ram,
	input  logic [a53_pkg::PPU_ADDR_W-1:0]  chr_ain,
	output logic [a53_pkg::MEM_ADDR_W-1:0]  prg_aout,
	output logic                            prg_allow,
	output logic [a53_pkg::MEM_ADDR_W-1:0]  chr_aout,
	output logic                            chr_allow,
	output logic                            vram_a10,
	output logic                            vram_ce
);

	logic                            bank_we;  // $8000+ write strobe
	logic [a53_pkg::SEL_W-1:0]       sel;
	logic [a53_pkg::INNER_W-1:0]     inner;
	logic [a53_pkg::OUTER_W-1:0]     outer;
	logic [a53_pkg::MODE_W-1:0]      mode;
	logic [a53_pkg::CHR_BANK_W-1:0]  chr_bank;

	a53_cpu_port i_a53_cpu_port (
		.clk       (clk),
		.arst_n    (arst_n),
		.ce        (ce),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.bank_we   (bank_we),
		.sel       (sel)
	);

	a53_bank_regs i_a53_bank_regs (
		.clk      (clk),
		.arst_n   (arst_n),
		.bank_we  (bank_we),
		.sel      (sel),
		.prg_din  (prg_din),
		.inner    (inner),
		.outer    (outer),
		.mode     (mode),
		.chr_bank (chr_bank)
	);

	a53_prg_map i_a53_prg_map (
		.prg_ain         (prg_ain),
		.prg_write       (prg_write),
		.prg_ram_present (prg_ram_present),
		.inner           (inner),
		.outer           (outer),
		.mode            (mode),
		.prg_aout        (prg_aout),
		.prg_allow       (prg_allow)
	);

	a53_ppu_map i_a53_ppu_map (
		.chr_ain    (chr_ain),
		.chr_is_ram (chr_is_ram),
		.mode       (mode),
		.chr_bank   (chr_bank),
		.chr_aout   (chr_aout),
		.chr_allow  (chr_allow),
		.vram_a10   (vram_a10),
		.vram_ce    (vram_ce)
	);

endmodule

`default_nettype wire

// File: test/a53_clk_gen.sv
// Testbench clock and reset generator
`timescale 1ns/100ps
`default_nettype none

module a53_clk_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk; // 10 ns period
		end
	end

	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk); // Reset held 8 cycles
		arst_n <= 1'b1;            // Released on a rising edge
	end

endmodule

`default_nettype wire

// File: test/a53_tb_tasks.svh
// Bus drivers, value checker and timeout waits
// Reference model of the register writes and the address mapping
`ifndef A53_TB_TASKS_SVH
`define A53_TB_TASKS_SVH

task automatic abort_run();
	$display("test failed");
	$fatal(1, "stopping at first failure");
endtask

task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
	if (actual !== expected) begin
		$display("** Error: %s expected 'h%0h, got 'h%0h", name, expected, actual);
		abort_run();
	end
endtask

// Returns at a falling edge with ce at the given level
task automatic wait_ce_level(input logic level);
	int n;
	n = 0;
	@(negedge clk);
	while (ce !== level) begin
		n++;
		if (n > max_wait) begin
			$display("Timeout: ce strobe never reached level %0d", level);
			abort_run();
		end
		@(negedge clk);
	end
endtask

task automatic wait_reset();
	int n;
	n = 0;
	@(negedge clk);
	while (arst_n !== 1'b1) begin
		n++;
		if (n > max_wait) begin
			$display("Timeout: reset was never released");
			abort_run();
		end
		@(negedge clk);
	end
endtask

// Model of the register file, per the write rules
function automatic void update_model(input logic [15:0] a, input logic [7:0] d);
	if (a[15:12] == 4'h5) begin
		m_sel = {d[7], d[0]};
	end else if (a[15]) begin
		case (m_sel)
			a53_pkg::SEL_CHR: begin
				m_chr = d[1:0];
				if (!m_mode[1]) m_mode[0] = d[4]; // Page bit in one-screen only
			end
			a53_pkg::SEL_INNER: begin
				m_inner = d[3:0];
				if (!m_mode[1]) m_mode[0] = d[4];
			end
			a53_pkg::SEL_MODE:  m_mode = d[5:0];
			default:            m_outer = d[5:0];
		endcase
	end
endfunction

task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
	wait_ce_level(1'b0); // ce rises on the next edge
	@(posedge clk);
	prg_ain   <= a;
	prg_write <= 1'b1;
	prg_din   <= d;
	@(posedge clk);      // Sampled here with ce high
	prg_write <= 1'b0;
	@(negedge clk);
	update_model(a, d);
endtask

// Write held only through a cycle with ce low
task automatic no_ce_write(input logic [15:0] a, input logic [7:0] d);
	wait_ce_level(1'b1); // ce falls on the next edge
	@(posedge clk);
	prg_ain   <= a;
	prg_write <= 1'b1;
	prg_din   <= d;
	@(posedge clk);
	prg_write <= 1'b0;
	@(negedge clk);
endtask

// Drives the buses in a ce low cycle, returns where outputs are settled
task automatic apply_bus(input logic [15:0] a, input logic w, input logic [13:0] c);
	wait_ce_level(1'b1);
	@(posedge clk);
	prg_ain   <= a;
	prg_write <= w;
	chr_ain   <= c;
	@(negedge clk);
endtask

task automatic release_write();
	@(posedge clk);
	prg_write <= 1'b0; // ce still low at this edge
endtask

task automatic write_reg(input logic [1:0] s, input logic [7:0] d);
	cpu_write(16'h5ABC, {s[1], 6'b010110, s[0]}); // Middle bits ignored
	cpu_write({1'b1, 15'($random(seed))}, d);
endtask

function automatic logic [6:0] ref_prg_bank(input logic a14);
	logic [6:0] bank;
	int s;
	int i;
	s = m_mode[5:4];
	bank = {m_outer, a14}; // Fixed half, also NROM base
	if (!m_mode[3]) begin
		for (i = 0; i < s; i++) begin
			bank[i+1] = m_inner[i]; // Low s outer bits from inner
		end
	end else if (a14 != m_mode[2]) begin
		bank = {m_outer, 1'b0}; // Switchable half
		for (i = 0; i <= s; i++) begin
			bank[i] = m_inner[i];
		end
	end
	return bank;
endfunction

function automatic logic [21:0] ref_prg_aout(input logic [15:0] a);
	if (a[15:13] == 3'b011 && prg_ram_present) begin
		return {a53_pkg::PRG_RAM_PREFIX, a[12:0]};
	end
	return {1'b0, ref_prg_bank(a[14]), a[13:0]};
endfunction

function automatic logic ref_prg_allow(input logic [15:0] a, input logic w);
	if (a[15:13] == 3'b011 && prg_ram_present) begin
		return 1'b1;
	end
	return a[15] && !w;
endfunction

function automatic logic [21:0] ref_chr_aout(input logic [13:0] c);
	return {a53_pkg::CHR_PREFIX, m_chr, c[12:0]};
endfunction

function automatic logic ref_vram_a10(input logic [13:0] c);
	case (m_mode[1:0])
		a53_pkg::MIR_VERT: return c[10];
		a53_pkg::MIR_HORZ: return c[11];
		default:           return m_mode[0]; // One-screen page
	endcase
endfunction

`endif

// File: test/a53_tb.sv
// Testbench top for the Action 53 mapper
// DUT, ce strobe and the directed test sequence
`timescale 1ns/100ps
`default_nettype none

module a53_tb;

	logic                           clk;
	logic                           arst_n;
	logic                           ce;
	logic [a53_pkg::CPU_ADDR_W-1:0] prg_ain;
	logic                           prg_write;
	logic [a53_pkg::DATA_W-1:0]     prg_din;
	logic                           prg_ram_present;
	logic                           chr_is_ram;
	logic [a53_pkg::PPU_ADDR_W-1:0] chr_ain;
	logic [a53_pkg::MEM_ADDR_W-1:0] prg_aout;
	logic                           prg_allow;
	logic [a53_pkg::MEM_ADDR_W-1:0] chr_aout;
	logic                           chr_allow;
	logic                           vram_a10;
	logic                           vram_ce;

	// Expected register state
	logic [a53_pkg::SEL_W-1:0]      m_sel;
	logic [a53_pkg::INNER_W-1:0]    m_inner;
	logic [a53_pkg::OUTER_W-1:0]    m_outer;
	logic [a53_pkg::MODE_W-1:0]     m_mode;
	logic [a53_pkg::CHR_BANK_W-1:0] m_chr;

	int seed;
	int max_wait;  // Edges per wait loop

	a53_clk_gen i_a53_clk_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	a53_top i_a53_top (
		.clk             (clk),
		.arst_n          (arst_n),
		.ce              (ce),
		.prg_ain         (prg_ain),
		.prg_write       (prg_write),
		.prg_din         (prg_din),
		.prg_ram_present (prg_ram_present),
		.chr_is_ram      (chr_is_ram),
		.chr_ain         (chr_ain),
		.prg_aout        (prg_aout),
		.prg_allow       (prg_allow),
		.chr_aout        (chr_aout),
		.chr_allow       (chr_allow),
		.vram_a10        (vram_a10),
		.vram_ce         (vram_ce)
	);

	// CPU cycle every other clock
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ce <= 1'b0;
		end else begin
			ce <= ~ce;
		end
	end

	`include "a53_tb_tasks.svh"

	task automatic test_reset_state();
		apply_bus(16'h8000, 1'b0, 14'h0155);
		check("prg_aout bank at $8000", 7'h7E, prg_aout[20:14]);
		check("vram_a10", 1'b0, vram_a10);
		check("chr_aout", {7'b1000000, 2'b00, 13'h0155}, chr_aout); // Bank 0
		apply_bus(16'hC000, 1'b0, 14'h0155);
		check("prg_aout bank at $C000", 7'h7F, prg_aout[20:14]);
		check("prg_aout", ref_prg_aout(16'hC000), prg_aout);
	endtask

	task automatic test_chr_banking();
		logic [13:0] c;
		int i;
		write_reg(a53_pkg::SEL_CHR, 8'($random(seed)));
		for (i = 0; i < 5; i++) begin
			c = (i == 0) ? 14'h1FFF : (i == 1) ? 14'h2000 : 14'($random(seed));
			apply_bus(16'h8000, 1'b0, c);
			check("chr_aout", ref_chr_aout(c), chr_aout);
			check("chr_allow", chr_is_ram, chr_allow);
			check("vram_ce", c[13], vram_ce);
		end
		@(posedge clk);
		chr_is_ram <= 1'b0; // CHR ROM board
		apply_bus(16'h8000, 1'b0, 14'h0400);
		check("chr_allow", 1'b0, chr_allow);
		@(posedge clk);
		chr_is_ram <= 1'b1;
	endtask

	task automatic test_prg_modes();
		logic [3:0]  combo; // Size and layout
		logic [15:0] a;
		int k;
		for (k = 0; k < 16; k++) begin
			combo = 4'(k);
			write_reg(a53_pkg::SEL_MODE, {2'b00, combo, a53_pkg::MIR_VERT});
			write_reg(a53_pkg::SEL_OUTER, 8'($random(seed)));
			write_reg(a53_pkg::SEL_INNER, 8'($random(seed)));
			a = {2'b10, 14'($random(seed))};
			apply_bus(a, 1'b0, 14'h0000);
			check("prg_aout at $8000 half", ref_prg_aout(a), prg_aout);
			a[14] = 1'b1;
			apply_bus(a, 1'b0, 14'h0000);
			check("prg_aout at $C000 half", ref_prg_aout(a), prg_aout);
		end
	endtask

	task automatic test_mirroring();
		int k;
		for (k = 0; k < 4; k++) begin
			write_reg(a53_pkg::SEL_MODE, {6'b000000, 2'(k)});
			apply_bus(16'h8000, 1'b0, 14'h2400); // A10 set
			check("vram_a10", ref_vram_a10(14'h2400), vram_a10);
			apply_bus(16'h8000, 1'b0, 14'h2800); // A11 set
			check("vram_a10", ref_vram_a10(14'h2800), vram_a10);
		end
		write_reg(a53_pkg::SEL_MODE, 8'h00);
		write_reg(a53_pkg::SEL_INNER, 8'h10); // Page bit moves the screen
		apply_bus(16'h8000, 1'b0, 14'h2000);
		check("vram_a10", 1'b1, vram_a10);
		write_reg(a53_pkg::SEL_MODE, 8'h02);
		write_reg(a53_pkg::SEL_INNER, 8'h13); // Vertical stays vertical
		apply_bus(16'h8000, 1'b0, 14'h2400);
		check("vram_a10", 1'b1, vram_a10);
		apply_bus(16'h8000, 1'b0, 14'h2800);
		check("vram_a10", 1'b0, vram_a10);
	endtask

	task automatic test_prg_ram();
		int p;
		for (p = 0; p < 2; p++) begin
			@(posedge clk);
			prg_ram_present <= (p == 0);
			apply_bus(16'h6000, 1'b0, 14'h0000);
			check("prg_aout at $6000", ref_prg_aout(16'h6000), prg_aout);
			check("prg_allow at $6000", ref_prg_allow(16'h6000, 1'b0), prg_allow);
			apply_bus(16'h7FFF, 1'b1, 14'h0000); // RAM write
			check("prg_aout at $7FFF", ref_prg_aout(16'h7FFF), prg_aout);
			check("prg_allow at $7FFF", ref_prg_allow(16'h7FFF, 1'b1), prg_allow);
			release_write();
			apply_bus(16'hA123, 1'b0, 14'h0000);
			check("prg_aout ROM read", ref_prg_aout(16'hA123), prg_aout);
			check("prg_allow ROM read", 1'b1, prg_allow);
			apply_bus(16'hE456, 1'b1, 14'h0000);
			check("prg_aout ROM write", ref_prg_aout(16'hE456), prg_aout);
			check("prg_allow ROM write", 1'b0, prg_allow);
			release_write();
		end
		@(posedge clk);
		prg_ram_present <= 1'b1;
	endtask

	task automatic test_no_ce();
		write_reg(a53_pkg::SEL_OUTER, 8'h2A);
		no_ce_write(16'h8000, 8'h15); // Would hit outer
		no_ce_write(16'h5000, 8'h00); // Would select CHR
		apply_bus(16'h8000, 1'b0, 14'h2C00);
		check("prg_aout at $8000", ref_prg_aout(16'h8000), prg_aout);
		check("chr_aout", ref_chr_aout(14'h2C00), chr_aout);
		check("vram_a10", ref_vram_a10(14'h2C00), vram_a10);
		apply_bus(16'hC000, 1'b0, 14'h2C00);
		check("prg_aout at $C000", ref_prg_aout(16'hC000), prg_aout);
		cpu_write(16'h8000, 8'h07); // Select must still be outer
		apply_bus(16'hC000, 1'b0, 14'h0000);
		check("prg_aout after outer write", ref_prg_aout(16'hC000), prg_aout);
	endtask

	initial begin
		ce              = 1'b0;
		prg_ain         = '0;
		prg_write       = 1'b0;
		prg_din         = '0;
		prg_ram_present = 1'b1;
		chr_is_ram      = 1'b1;
		chr_ain         = '0;
		m_sel           = a53_pkg::SEL_RESET;
		m_inner         = '0;
		m_outer         = a53_pkg::OUTER_RESET;
		m_mode          = '0;
		m_chr           = '0;
		seed            = 1;
		max_wait        = 32;
		wait_reset();
		test_reset_state();
		test_chr_banking();
		test_prg_modes();
		test_mirroring();
		test_prg_ram();
		test_no_ce();
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+test
rtl/a53_pkg.sv
rtl/a53_cpu_port.sv
rtl/a53_bank_regs.sv
rtl/a53_prg_map.sv
rtl/a53_ppu_map.sv
rtl/a53_top.sv
test/a53_clk_gen.sv
test/a53_tb.sv
